//--- hdl/tilemap_pkg.sv
// ====================
// tilemap package
// renderer states, video timing constants
// and bus widths shared by the scroll layer
// ====================
package tilemap_pkg;

    // line renderer FSM
    typedef enum logic [2:0] {
        idle,       // waiting for start
        map_code,   // tile code read from VRAM
        map_attr,   // tile attribute read from VRAM
        rom_req,    // graphics address setup
        rom_wait,   // graphics word read
        unpack,     // 8 pixels out to the line buffer
        line_done   // line complete
    } render_state_t;

    // horizontal timing in pixels
    localparam int h_visible = 384;
    localparam int h_total   = 512;

    // clocks per pixel
    localparam int pixel_div = 4;

    // line buffer entry of palette nibble over colour nibble
    localparam int pixel_w = 8;
    localparam int buf_aw  = 9;

    // external memory address widths
    localparam int vram_aw = 24;
    localparam int rom_aw  = 23;

endpackage

//--- hdl/video_timing.sv
// ====================
// video timing
// pixel enable, beam counters, render start
// and line buffer scan-out
// ====================
module video_timing import tilemap_pkg::*; #(
    parameter int v_visible = 224,
    parameter int v_total   = 262
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       render_done,
    output logic       pxl_cen,
    output logic [8:0] hcnt,
    output logic [8:0] vcnt,
    output logic       render_start,
    output logic [8:0] render_v,
    output logic       swap,
    output logic [8:0] rd_addr,
    output logic       pixel_valid,
    output logic [8:0] pixel_h,
    output logic [8:0] pixel_v
);

    localparam int cen_w = $clog2(pixel_div);
    localparam logic [cen_w-1:0] cen_last = cen_w'(pixel_div - 1);
    localparam logic [8:0] h_last = 9'(h_total - 1);
    localparam logic [8:0] v_last = 9'(v_total - 1);

    logic [cen_w-1:0] cen_cnt;
    logic             running;      // first frame after reset is dark
    logic             busy;         // renderer still drawing
    logic             line_start;
    logic             vis_q;
    logic [8:0]       v_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            cen_cnt <= cen_cnt == cen_last ? '0 : cen_cnt + 1'b1;
            pxl_cen <= cen_cnt == cen_last;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt    <= 9'd0;
            vcnt    <= 9'd0;
            running <= 1'b0;
        end else if (pxl_cen) begin
            if (hcnt == h_last) begin
                hcnt <= 9'd0;
                if (vcnt == v_last) begin
                    vcnt    <= 9'd0;
                    running <= 1'b1;
                end else begin
                    vcnt <= vcnt + 9'd1;
                end
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    assign line_start   = pxl_cen && running && hcnt == 9'd0;
    assign swap         = line_start;
    assign render_start = line_start && !busy;      // never restart mid-line
    assign render_v     = vcnt == v_last ? 9'd0 : vcnt + 9'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (render_start) begin
            busy <= 1'b1;
        end else if (render_done) begin
            busy <= 1'b0;
        end
    end

    // read address, then output one clock later with the buffer data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_addr     <= 9'd0;
            v_q         <= 9'd0;
            vis_q       <= 1'b0;
            pixel_valid <= 1'b0;
            pixel_h     <= 9'd0;
            pixel_v     <= 9'd0;
        end else begin
            if (pxl_cen) begin
                rd_addr <= hcnt;
                v_q     <= vcnt;
            end
            vis_q       <= pxl_cen && running && hcnt < 9'(h_visible)
                           && vcnt < 9'(v_visible);
            pixel_valid <= vis_q;
            pixel_h     <= rd_addr;
            pixel_v     <= v_q;
        end
    end

endmodule

//--- hdl/tile_line_render.sv
// ====================
// tile line renderer
// scans one line of the tile map, fetches the
// planar graphics and writes colour indices
// into the back bank of the line buffer
// ====================
module tile_line_render import tilemap_pkg::*; #(
    parameter int tile_size = 8     // 8, 16 or 32
) (
    input  logic                clk,
    input  logic                rst,

    input  logic [8:0]          v,          // line to draw
    input  logic [15:0]         vram_base,
    input  logic [15:0]         hpos,
    input  logic [15:0]         vpos,

    input  logic                start,
    output logic                done,

    output logic [vram_aw-1:0]  vram_addr,
    input  logic [15:0]         vram_data,
    input  logic                vram_ok,
    output logic                vram_cs,

    output logic [rom_aw-1:0]   rom_addr,
    input  logic [31:0]         rom_data,
    input  logic                rom_ok,
    output logic                rom_cs,

    output logic [buf_aw-1:0]   buf_addr,
    output logic [pixel_w-1:0]  buf_data,
    output logic                buf_wr
);

    // graphics bank per tile size
    localparam logic [2:0] rom_id = tile_size == 8  ? 3'd1 :
                                    tile_size == 16 ? 3'd2 : 3'd3;
    localparam logic [10:0] tile_mask = 11'(tile_size - 1);
    localparam logic [buf_aw-1:0] last_addr = buf_aw'(h_visible - 1);

    render_state_t state;

    logic [10:0]       vn;          // scrolled row
    logic [10:0]       hn;          // scrolled column, multiple of 8
    logic [buf_aw-1:0] wr_ptr;
    logic [2:0]        bit_cnt;     // pixel within the 8-pixel group
    logic [15:0]       code;
    logic [3:0]        pal;
    logic [31:0]       pxl_data;

    logic [11:0] scan;
    logic [19:0] rom_word;
    logic        last_px;
    logic        tile_end;

    // one map scan layout per map size
    always_comb begin
        case (tile_size)
            8:       scan = {vn[8],    hn[8:3],  vn[7:3]};  // 512 x 512 map
            16:      scan = {vn[9:8],  hn[9:4],  vn[7:4]};  // 1024 x 1024 map
            default: scan = {vn[10:8], hn[10:5], vn[7:5]};  // 2048 x 2048 map
        endcase
    end

    // graphics word within the bank
    always_comb begin
        case (tile_size)
            8:       rom_word = {1'b0, code, vn[2:0]};
            16:      rom_word = {code[14:0], vn[3:0], hn[3]};
            // hn[4] picks the half tile and hn[3] the word in it
            default: rom_word = {code[12:0], vn[4:0], hn[4:3]};
        endcase
    end

    assign last_px  = wr_ptr == last_addr;
    assign tile_end = (hn & tile_mask) == 11'd0;   // hn already moved on

    function automatic logic [3:0] colour(input logic [31:0] c);
        return {c[31], c[23], c[15], c[7]};         // one bit per plane
    endfunction

    // control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= idle;
            vram_cs <= 1'b0;
            rom_cs  <= 1'b0;
            buf_wr  <= 1'b0;
            done    <= 1'b0;
        end else begin
            buf_wr <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        done  <= 1'b0;
                        state <= map_code;
                    end
                end
                map_code: begin
                    if (!vram_cs) begin
                        vram_cs <= 1'b1;        // address set this cycle
                    end else if (vram_ok) begin
                        state <= map_attr;      // cs stays up for attr word
                    end
                end
                map_attr: begin
                    if (vram_ok) begin
                        vram_cs <= 1'b0;
                        state   <= rom_req;
                    end
                end
                rom_req: begin
                    rom_cs <= 1'b1;
                    state  <= rom_wait;
                end
                rom_wait: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        state  <= unpack;
                    end
                end
                unpack: begin
                    buf_wr <= 1'b1;
                    if (last_px) begin
                        state <= line_done;
                    end else if (bit_cnt == 3'd7) begin
                        state <= tile_end ? map_code : rom_req;
                    end
                end
                line_done: begin
                    done  <= 1'b1;              // held until next start
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    vn     <= vpos[10:0] + {2'd0, v};
                    hn     <= {hpos[10:3], 3'd0};
                    wr_ptr <= 9'd0 - {6'd0, hpos[2:0]};  // fine scroll
                end
            end
            map_code: begin
                if (!vram_cs) begin
                    vram_addr <= {vram_base, 8'd0} + {11'd0, scan, 1'b0};
                end else if (vram_ok) begin
                    code      <= vram_data;
                    vram_addr <= vram_addr + 24'd1;     // attribute word
                end
            end
            map_attr: begin
                if (vram_ok) begin
                    pal <= vram_data[3:0];
                end
            end
            rom_req: begin
                rom_addr <= {rom_id, rom_word};
            end
            rom_wait: begin
                if (rom_ok) begin
                    pxl_data <= rom_data;               // 8 pixels in 4 planes
                    hn       <= hn + 11'd8;
                    bit_cnt  <= 3'd0;
                end
            end
            unpack: begin
                buf_addr <= wr_ptr;
                buf_data <= {pal, colour(pxl_data)};
                pxl_data <= pxl_data << 1;
                wr_ptr   <= wr_ptr + 9'd1;
                bit_cnt  <= bit_cnt + 3'd1;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/line_buffer.sv
// ====================
// line buffer
// two banks of one line each, the renderer
// fills the back bank while the front is shown
// ====================
module line_buffer import tilemap_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               swap,
    input  logic               wr,
    input  logic [buf_aw-1:0]  wr_addr,
    input  logic [pixel_w-1:0] wr_data,
    input  logic [buf_aw-1:0]  rd_addr,
    output logic [pixel_w-1:0] rd_data
);

    logic [pixel_w-1:0] mem [2][h_visible];

    logic       front;      // bank on display
    logic [1:0] valid;      // bank holds a finished line
    logic       written;    // back bank touched since last swap
    logic       wr_ok;
    logic       rd_ok;

    assign wr_ok = wr && (wr_addr < buf_aw'(h_visible));     // drop scroll wrap
    assign rd_ok = valid[front] && (rd_addr < buf_aw'(h_visible));

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[~front][wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            front   <= 1'b0;
            valid   <= 2'b00;
            written <= 1'b0;
            rd_data <= '0;
        end else begin
            if (swap) begin
                front          <= ~front;
                valid[~front]  <= valid[~front] | written | wr_ok;
                written        <= 1'b0;
            end else if (wr_ok) begin
                written <= 1'b1;
            end
            rd_data <= rd_ok ? mem[front][rd_addr] : '0;
        end
    end

endmodule

//--- hdl/tilemap_layer.sv
// ====================
// tilemap scroll layer
// timing, line renderer and line buffer
// ====================
module tilemap_layer import tilemap_pkg::*; #(
    parameter int tile_size = 8,
    parameter int v_visible = 224,
    parameter int v_total   = 262
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [15:0]         vram_base,
    input  logic [15:0]         hpos,
    input  logic [15:0]         vpos,

    output logic [vram_aw-1:0]  vram_addr,
    output logic                vram_cs,
    input  logic [15:0]         vram_data,
    input  logic                vram_ok,

    output logic [rom_aw-1:0]   rom_addr,
    output logic                rom_cs,
    input  logic [31:0]         rom_data,
    input  logic                rom_ok,

    output logic [pixel_w-1:0]  pixel,
    output logic [8:0]          pixel_h,
    output logic [8:0]          pixel_v,
    output logic                pixel_valid
);

    logic               render_start;
    logic               render_done;
    logic [8:0]         render_v;
    logic               swap;
    logic [buf_aw-1:0]  rd_addr;
    logic               buf_wr;
    logic [buf_aw-1:0]  buf_addr;
    logic [pixel_w-1:0] buf_data;

    video_timing #(
        .v_visible (v_visible),
        .v_total   (v_total)
    ) timing_i (
        .clk          (clk),
        .rst          (rst),
        .render_done  (render_done),
        .pxl_cen      (),               // counters kept internal
        .hcnt         (),
        .vcnt         (),
        .render_start (render_start),
        .render_v     (render_v),
        .swap         (swap),
        .rd_addr      (rd_addr),
        .pixel_valid  (pixel_valid),
        .pixel_h      (pixel_h),
        .pixel_v      (pixel_v)
    );

    tile_line_render #(
        .tile_size (tile_size)
    ) render_i (
        .clk       (clk),
        .rst       (rst),
        .v         (render_v),
        .vram_base (vram_base),
        .hpos      (hpos),
        .vpos      (vpos),
        .start     (render_start),
        .done      (render_done),
        .vram_addr (vram_addr),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .vram_cs   (vram_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_cs    (rom_cs),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .buf_wr    (buf_wr)
    );

    line_buffer buf_i (
        .clk     (clk),
        .rst     (rst),
        .swap    (swap),
        .wr      (buf_wr),
        .wr_addr (buf_addr),
        .wr_data (buf_data),
        .rd_addr (rd_addr),
        .rd_data (pixel)
    );

endmodule

//--- sim/tb_mem_models.sv
// ====================
// VRAM and ROM models
// cs/ok handshake with LFSR wait states
// ====================
module tb_mem_models (
    input  logic        clk,
    input  logic [23:0] vram_addr,
    input  logic        vram_cs,
    output logic [15:0] vram_data,
    output logic        vram_ok,
    input  logic [22:0] rom_addr,
    input  logic        rom_cs,
    output logic [31:0] rom_data,
    output logic        rom_ok
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] lfsr;
    logic        vram_busy;
    logic        rom_busy;
    int          vram_left;
    int          rom_left;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // 0 to 3 wait cycles from two bits
    task automatic draw_wait(output int n);
        lfsr = lfsr_next(lfsr);
        n = lfsr[0];
        lfsr = lfsr_next(lfsr);
        n = n * 2 + lfsr[0];
    endtask

    // upper address byte folded into the low byte
    function automatic logic [15:0] vram_content(input logic [23:0] a);
        return a[15:0] ^ {8'd0, a[23:16]} ^ 16'h5a3c;
    endfunction

    function automatic logic [31:0] rom_content(input logic [22:0] a);
        logic [45:0] twice;
        twice = {a, a};
        return twice[31:0] ^ 32'hc0ffee11;
    endfunction

    initial begin
        lfsr      = 16'd52;
        vram_ok   = 1'b0;
        vram_data = 16'd0;
        rom_ok    = 1'b0;
        rom_data  = 32'd0;
        vram_busy = 1'b0;
        rom_busy  = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (vram_ok) begin
                vram_ok = 1'b0;                 // one ack per request
            end else if (vram_cs) begin
                if (!vram_busy) begin
                    draw_wait(vram_left);
                    vram_busy = 1'b1;
                end
                if (vram_left == 0) begin
                    vram_ok   = 1'b1;
                    vram_data = vram_content(vram_addr);
                    vram_busy = 1'b0;
                end else begin
                    vram_left = vram_left - 1;
                end
            end
            if (rom_ok) begin
                rom_ok = 1'b0;
            end else if (rom_cs) begin
                if (!rom_busy) begin
                    draw_wait(rom_left);
                    rom_busy = 1'b1;
                end
                if (rom_left == 0) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_content(rom_addr);
                    rom_busy = 1'b0;
                end else begin
                    rom_left = rom_left - 1;
                end
            end
        end
    end

endmodule

//--- sim/tb_tilemap.sv
// ====================
// tilemap layer testbench
// scroll table, reference pixel model
// ====================
module tb_tilemap import tilemap_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int v_visible  = 6;
    localparam int v_total    = 8;
    localparam int n_rows     = 9;
    localparam int frame_clks = h_total * pixel_div * v_total;
    localparam int limit_clks = (n_rows + 2) * 3 * frame_clks;  // 3 frames per row

    logic        clk;
    logic        rst;
    logic [15:0] vram_base;
    logic [15:0] hpos;
    logic [15:0] vpos;
    logic [23:0] vram_addr;
    logic        vram_cs;
    logic [15:0] vram_data;
    logic        vram_ok;
    logic [22:0] rom_addr;
    logic        rom_cs;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic [7:0]  pixel;
    logic [8:0]  pixel_h;
    logic [8:0]  pixel_v;
    logic        pixel_valid;

    string       row_name [n_rows];
    logic [15:0] row_base [n_rows];
    logic [15:0] row_hpos [n_rows];
    logic [15:0] row_vpos [n_rows];

    tilemap_layer #(.tile_size(8), .v_visible(v_visible), .v_total(v_total)) dut_i (.*);

    tb_mem_models mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic set_row(input int i, input string name, input logic [15:0] base,
                           input logic [15:0] h, input logic [15:0] v);
        row_name[i] = name;
        row_base[i] = base;
        row_hpos[i] = h;
        row_vpos[i] = v;
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0h, actual %0h", what, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // VRAM fill with the upper address byte folded in
    function automatic logic [15:0] vram_word(input logic [23:0] a);
        return a[15:0] ^ {8'd0, a[23:16]} ^ 16'h5a3c;
    endfunction

    // pixel for screen (h, v) of a 512 x 512 map of 8-pixel tiles
    function automatic logic [7:0] expected_pixel(input logic [15:0] base, input logic [15:0] hs,
                                                  input logic [15:0] vs, input int h, input int v);
        logic [10:0] x;
        logic [10:0] y;
        logic [11:0] tile_index;
        logic [23:0] map_addr;
        logic [23:0] attr_addr;
        logic [15:0] code;
        logic [15:0] attr;
        logic [22:0] gfx_addr;
        logic [45:0] twice;
        logic [31:0] gfx;
        int          k;
        x = hs[10:0] + 11'(h);
        y = vs[10:0] + 11'(v);
        tile_index = {y[8], x[8:3], y[7:3]};        // lower/upper half, column, row
        map_addr = {base, 8'd0} + {11'd0, tile_index, 1'b0};
        attr_addr = map_addr + 24'd1;
        code = vram_word(map_addr);
        attr = vram_word(attr_addr);
        gfx_addr = {3'd1, 1'b0, code, y[2:0]};
        twice = {gfx_addr, gfx_addr};
        gfx = twice[31:0] ^ 32'hc0ffee11;
        k = x[2:0];
        return {attr[3:0], gfx[31 - k], gfx[23 - k], gfx[15 - k], gfx[7 - k]};
    endfunction

    task automatic wait_frame_start();
        @(negedge clk);
        while (!(pixel_valid && pixel_v == 9'd0 && pixel_h == 9'd0)) begin
            @(negedge clk);
        end
    endtask

    // starts on the first pixel of a frame
    task automatic check_frame(input int row, input bit blank, input int n_pixels);
        int    count;
        int    h;
        int    v;
        string where;
        count = 0;
        while (count < n_pixels) begin
            if (pixel_valid) begin
                h = count % h_visible;
                v = count / h_visible;
                where = $sformatf("%s (%0d,%0d)", blank ? "reset" : row_name[row], h, v);
                compare_value({where, " column"}, h, pixel_h);
                compare_value({where, " line"}, v, pixel_v);
                compare_value({where, " pixel"}, blank ? 32'd0 :
                              expected_pixel(row_base[row], row_hpos[row], row_vpos[row], h, v),
                              pixel);
                count++;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        repeat (limit_clks) @(posedge clk);
        $display("watchdog: pixel output stopped before all rows were checked");
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst       = 1'b1;
        vram_base = 16'd0;
        hpos      = 16'd0;
        vpos      = 16'd0;
        set_row(0, "plain", 16'h0000, 16'd0, 16'd0);
        set_row(1, "fine_1", 16'h0000, 16'd1, 16'd0);
        set_row(2, "fine_7", 16'h0000, 16'd7, 16'd0);
        set_row(3, "coarse", 16'h0000, 16'd300, 16'd0);
        set_row(4, "h_wrap", 16'h0000, 16'h07fd, 16'd0);
        set_row(5, "v_scroll", 16'h0000, 16'd0, 16'd37);
        set_row(6, "v_wrap", 16'h0000, 16'd0, 16'd509);
        set_row(7, "base", 16'h0123, 16'd5, 16'd3);
        set_row(8, "mixed", 16'h5ca7, 16'd91, 16'h07fe);
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
        // timing idles through the whole first frame
        repeat ((v_total - 1) * h_total * pixel_div) begin
            @(negedge clk);
            compare_value("idle vram_cs", 32'd0, vram_cs);
            compare_value("idle rom_cs", 32'd0, rom_cs);
            compare_value("idle pixel_valid", 32'd0, pixel_valid);
        end
        wait_frame_start();
        check_frame(0, 1'b1, h_visible);    // line 0 has no rendered line yet
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            #2;
            vram_base = row_base[i];
            hpos      = row_hpos[i];
            vpos      = row_vpos[i];
            wait_frame_start();
            wait_frame_start();             // first frame fully drawn with the new row
            check_frame(i, 1'b0, h_visible * v_visible);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

//--- flist.f
hdl/tilemap_pkg.sv
hdl/video_timing.sv
hdl/tile_line_render.sv
hdl/line_buffer.sv
hdl/tilemap_layer.sv
sim/tb_mem_models.sv
sim/tb_tilemap.sv

//--- Bender.yml
package:
  name: tilemap_layer

sources:
  - files:
      - hdl/tilemap_pkg.sv
      - hdl/video_timing.sv
      - hdl/tile_line_render.sv
      - hdl/line_buffer.sv
      - hdl/tilemap_layer.sv
  - target: simulation
    files:
      - sim/tb_mem_models.sv
      - sim/tb_tilemap.sv
